// ==== hw/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

  localparam int data_width_lp = 32;
  localparam int lane_width_lp = 8;
  localparam int lane_count_lp = 4;
  localparam int reg_count_lp  = 16;

  // Instruction field positions
  localparam int opcode_msb_lp = 31;
  localparam int opcode_lsb_lp = 28;
  localparam int rd_msb_lp     = 27;
  localparam int rd_lsb_lp     = 24;
  localparam int rs1_msb_lp    = 23;
  localparam int rs1_lsb_lp    = 20;
  localparam int rs2_msb_lp    = 19;
  localparam int rs2_lsb_lp    = 16;
  localparam int imm_width_lp  = 16;
  localparam int imm_lsb_lp    = 0;
  localparam int imm_msb_lp    = imm_lsb_lp + imm_width_lp - 1;

  typedef logic [$clog2(reg_count_lp)-1:0] reg_addr_t;

  // Four lanes packed into one word, lane 0 in the low byte
  typedef logic [lane_count_lp-1:0][lane_width_lp-1:0] lane_vec_t;

  typedef enum logic [3:0] {
    op_nop, op_add, op_sub, op_and, op_or, op_addi,
    op_vadd, op_vsub, op_vand, op_vor, op_vadds,
    op_lw, op_sw, op_vlw, op_vsw
  } opcode_e;

  typedef enum logic [1:0] {alu_add, alu_sub, alu_and, alu_or} alu_op_e;

endpackage

// ==== hw/cpu_pipe_pkg.sv ====
package cpu_pipe_pkg;

  // Decoded control, all zero for a no-op
  typedef struct packed {
    logic                 reg_we;
    logic                 is_vector;
    logic                 use_imm;
    logic                 broadcast;
    logic                 mem_read;
    logic                 mem_write;
    cpu_isa_pkg::alu_op_e alu_op;
  } ctrl_t;

  typedef struct packed {
    ctrl_t                                 ctrl;
    cpu_isa_pkg::reg_addr_t                rd;
    logic [cpu_isa_pkg::data_width_lp-1:0] rs1_s;
    logic [cpu_isa_pkg::data_width_lp-1:0] rs2_s;
    cpu_isa_pkg::lane_vec_t                rs1_v;
    cpu_isa_pkg::lane_vec_t                rs2_v;
    logic [cpu_isa_pkg::data_width_lp-1:0] imm;
  } id_ex_t;

  // result_s doubles as the memory address for loads and stores
  typedef struct packed {
    ctrl_t                                 ctrl;
    cpu_isa_pkg::reg_addr_t                rd;
    logic [cpu_isa_pkg::data_width_lp-1:0] result_s;
    cpu_isa_pkg::lane_vec_t                result_v;
    logic [cpu_isa_pkg::data_width_lp-1:0] store_data;
  } ex_mem_t;

endpackage

// ==== hw/rf_write_if.sv ====
`timescale 1ns/1ns

interface rf_write_if;

  logic                                  we;
  cpu_isa_pkg::reg_addr_t                addr;
  logic                                  is_vector;
  logic [cpu_isa_pkg::data_width_lp-1:0] sdata;
  cpu_isa_pkg::lane_vec_t                vdata;

  modport wb (output we, addr, is_vector, sdata, vdata);
  modport rf (input we, addr, is_vector, sdata, vdata);

endinterface

// ==== hw/fetch_stage.sv ====
`timescale 1ns/1ns

module fetch_stage (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  logic [cpu_isa_pkg::data_width_lp-1:0] inst_i,
  output logic [cpu_isa_pkg::data_width_lp-1:0] pc_o,
  output logic [cpu_isa_pkg::data_width_lp-1:0] inst_o
);

  logic [cpu_isa_pkg::data_width_lp-1:0] pc_q;
  logic [cpu_isa_pkg::data_width_lp-1:0] inst_q;

  // Word addressed, one instruction per cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q   <= '0;
      inst_q <= '0;
    end else begin
      pc_q   <= pc_q + 1'b1;
      inst_q <= inst_i;
    end
  end

  assign pc_o   = pc_q;
  assign inst_o = inst_q;

endmodule

// ==== hw/register_file.sv ====
`timescale 1ns/1ns

module register_file (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  cpu_isa_pkg::reg_addr_t                rs1_addr_i,
  input  cpu_isa_pkg::reg_addr_t                rs2_addr_i,
  output logic [cpu_isa_pkg::data_width_lp-1:0] rs1_s_o,
  output logic [cpu_isa_pkg::data_width_lp-1:0] rs2_s_o,
  output cpu_isa_pkg::lane_vec_t                rs1_v_o,
  output cpu_isa_pkg::lane_vec_t                rs2_v_o,
  rf_write_if.rf                                wr
);

  logic [cpu_isa_pkg::data_width_lp-1:0] scalar_q [cpu_isa_pkg::reg_count_lp];
  cpu_isa_pkg::lane_vec_t                vector_q [cpu_isa_pkg::reg_count_lp];

  // Only the bank named by is_vector is written
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      scalar_q <= '{default: '0};
      vector_q <= '{default: '0};
    end else if (wr.we) begin
      if (wr.is_vector) begin
        vector_q[wr.addr] <= wr.vdata;
      end else begin
        scalar_q[wr.addr] <= wr.sdata;
      end
    end
  end

  // No bypass, a same-cycle read sees the old value
  assign rs1_s_o = scalar_q[rs1_addr_i];
  assign rs2_s_o = scalar_q[rs2_addr_i];
  assign rs1_v_o = vector_q[rs1_addr_i];
  assign rs2_v_o = vector_q[rs2_addr_i];

  // Write-back comes from the memory stage
  a_wr_addr_known: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    wr.we |-> !$isunknown(wr.addr)
  );

endmodule

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  logic [cpu_isa_pkg::data_width_lp-1:0] inst_i,
  output cpu_isa_pkg::reg_addr_t                rs1_addr_o,
  output cpu_isa_pkg::reg_addr_t                rs2_addr_o,
  input  logic [cpu_isa_pkg::data_width_lp-1:0] rs1_s_i,
  input  logic [cpu_isa_pkg::data_width_lp-1:0] rs2_s_i,
  input  cpu_isa_pkg::lane_vec_t                rs1_v_i,
  input  cpu_isa_pkg::lane_vec_t                rs2_v_i,
  output cpu_pipe_pkg::id_ex_t                  id_ex_o
);

  cpu_isa_pkg::opcode_e                  opcode;
  cpu_pipe_pkg::ctrl_t                   ctrl;
  logic [cpu_isa_pkg::data_width_lp-1:0] imm_ext;
  cpu_pipe_pkg::id_ex_t                  id_ex_q;

  assign opcode = cpu_isa_pkg::opcode_e'(
    inst_i[cpu_isa_pkg::opcode_msb_lp:cpu_isa_pkg::opcode_lsb_lp]);
  assign rs1_addr_o = inst_i[cpu_isa_pkg::rs1_msb_lp:cpu_isa_pkg::rs1_lsb_lp];
  assign rs2_addr_o = inst_i[cpu_isa_pkg::rs2_msb_lp:cpu_isa_pkg::rs2_lsb_lp];

  assign imm_ext = {
    {(cpu_isa_pkg::data_width_lp - cpu_isa_pkg::imm_width_lp){
      inst_i[cpu_isa_pkg::imm_msb_lp]}},
    inst_i[cpu_isa_pkg::imm_msb_lp:cpu_isa_pkg::imm_lsb_lp]
  };

  always_comb begin
    ctrl = '0;
    case (opcode)
      cpu_isa_pkg::op_add:   {ctrl.reg_we, ctrl.alu_op} = {1'b1, cpu_isa_pkg::alu_add};
      cpu_isa_pkg::op_sub:   {ctrl.reg_we, ctrl.alu_op} = {1'b1, cpu_isa_pkg::alu_sub};
      cpu_isa_pkg::op_and:   {ctrl.reg_we, ctrl.alu_op} = {1'b1, cpu_isa_pkg::alu_and};
      cpu_isa_pkg::op_or:    {ctrl.reg_we, ctrl.alu_op} = {1'b1, cpu_isa_pkg::alu_or};
      cpu_isa_pkg::op_addi:  {ctrl.reg_we, ctrl.use_imm} = 2'b11;
      cpu_isa_pkg::op_vadd:  {ctrl.reg_we, ctrl.is_vector} = 2'b11;
      cpu_isa_pkg::op_vsub:  {ctrl.reg_we, ctrl.is_vector, ctrl.alu_op} =
                             {2'b11, cpu_isa_pkg::alu_sub};
      cpu_isa_pkg::op_vand:  {ctrl.reg_we, ctrl.is_vector, ctrl.alu_op} =
                             {2'b11, cpu_isa_pkg::alu_and};
      cpu_isa_pkg::op_vor:   {ctrl.reg_we, ctrl.is_vector, ctrl.alu_op} =
                             {2'b11, cpu_isa_pkg::alu_or};
      cpu_isa_pkg::op_vadds: {ctrl.reg_we, ctrl.is_vector, ctrl.broadcast} = 3'b111;
      // Memory ops add the immediate to rs1 for the address
      cpu_isa_pkg::op_lw:    {ctrl.reg_we, ctrl.use_imm, ctrl.mem_read} = 3'b111;
      cpu_isa_pkg::op_sw:    {ctrl.use_imm, ctrl.mem_write} = 2'b11;
      cpu_isa_pkg::op_vlw:   {ctrl.reg_we, ctrl.is_vector, ctrl.use_imm, ctrl.mem_read} = 4'hf;
      cpu_isa_pkg::op_vsw:   {ctrl.is_vector, ctrl.use_imm, ctrl.mem_write} = 3'b111;
      default:               ctrl = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      id_ex_q <= '0;
    end else begin
      id_ex_q.ctrl  <= ctrl;
      id_ex_q.rd    <= inst_i[cpu_isa_pkg::rd_msb_lp:cpu_isa_pkg::rd_lsb_lp];
      id_ex_q.rs1_s <= rs1_s_i;
      id_ex_q.rs2_s <= rs2_s_i;
      id_ex_q.rs1_v <= rs1_v_i;
      id_ex_q.rs2_v <= rs2_v_i;
      id_ex_q.imm   <= imm_ext;
    end
  end

  assign id_ex_o = id_ex_q;

  a_no_read_and_write: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    !(id_ex_o.ctrl.mem_read && id_ex_o.ctrl.mem_write)
  );

endmodule

// ==== hw/execute_stage.sv ====
`timescale 1ns/1ns

module execute_stage (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  cpu_pipe_pkg::id_ex_t  id_ex_i,
  output cpu_pipe_pkg::ex_mem_t ex_mem_o
);

  logic [cpu_isa_pkg::data_width_lp-1:0] op_b_s;
  logic [cpu_isa_pkg::data_width_lp-1:0] result_s;
  cpu_isa_pkg::lane_vec_t                op_b_v;
  cpu_isa_pkg::lane_vec_t                result_v;
  cpu_pipe_pkg::ex_mem_t                 ex_mem_q;

  // Shared by the scalar ALU and the lanes
  function automatic logic [cpu_isa_pkg::data_width_lp-1:0] alu_f(
    input cpu_isa_pkg::alu_op_e                op,
    input logic [cpu_isa_pkg::data_width_lp-1:0] a,
    input logic [cpu_isa_pkg::data_width_lp-1:0] b
  );
    case (op)
      cpu_isa_pkg::alu_add: return a + b;
      cpu_isa_pkg::alu_sub: return a - b;
      cpu_isa_pkg::alu_and: return a & b;
      default:              return a | b;
    endcase
  endfunction

  assign op_b_s   = id_ex_i.ctrl.use_imm ? id_ex_i.imm : id_ex_i.rs2_s;
  assign result_s = alu_f(id_ex_i.ctrl.alu_op, id_ex_i.rs1_s, op_b_s);

  for (genvar lane = 0; lane < cpu_isa_pkg::lane_count_lp; lane++) begin : g_lane
    logic [cpu_isa_pkg::data_width_lp-1:0] lane_full;

    // Low byte of scalar rs2 copied to every lane for vadds
    assign op_b_v[lane] = id_ex_i.ctrl.broadcast ?
                          id_ex_i.rs2_s[cpu_isa_pkg::lane_width_lp-1:0] :
                          id_ex_i.rs2_v[lane];
    // Lanes run zero-extended and keep only the low byte
    assign lane_full = alu_f(
      id_ex_i.ctrl.alu_op,
      {{(cpu_isa_pkg::data_width_lp - cpu_isa_pkg::lane_width_lp){1'b0}},
       id_ex_i.rs1_v[lane]},
      {{(cpu_isa_pkg::data_width_lp - cpu_isa_pkg::lane_width_lp){1'b0}},
       op_b_v[lane]}
    );
    assign result_v[lane] = lane_full[cpu_isa_pkg::lane_width_lp-1:0];
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ex_mem_q <= '0;
    end else begin
      ex_mem_q.ctrl       <= id_ex_i.ctrl;
      ex_mem_q.rd         <= id_ex_i.rd;
      ex_mem_q.result_s   <= result_s;
      ex_mem_q.result_v   <= result_v;
      ex_mem_q.store_data <= id_ex_i.ctrl.is_vector ? id_ex_i.rs2_v : id_ex_i.rs2_s;
    end
  end

  assign ex_mem_o = ex_mem_q;

endmodule

// ==== hw/memory_stage.sv ====
`timescale 1ns/1ns

module memory_stage (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  cpu_pipe_pkg::ex_mem_t                 ex_mem_i,
  input  logic [cpu_isa_pkg::data_width_lp-1:0] data_mem_out_data_i,
  output logic [cpu_isa_pkg::data_width_lp-1:0] data_mem_address_o,
  output logic [cpu_isa_pkg::data_width_lp-1:0] data_mem_in_data_o,
  output logic                                  data_mem_we_o,
  rf_write_if.wb                                wr
);

  cpu_pipe_pkg::ctrl_t                   wb_ctrl_q;
  cpu_isa_pkg::reg_addr_t                wb_rd_q;
  logic [cpu_isa_pkg::data_width_lp-1:0] load_q;
  logic [cpu_isa_pkg::data_width_lp-1:0] result_s_q;
  cpu_isa_pkg::lane_vec_t                result_v_q;

  // Data memory reads combinationally in this cycle
  assign data_mem_address_o = ex_mem_i.result_s;
  assign data_mem_in_data_o = ex_mem_i.store_data;
  assign data_mem_we_o      = ex_mem_i.ctrl.mem_write;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_ctrl_q  <= '0;
      wb_rd_q    <= '0;
      load_q     <= '0;
      result_s_q <= '0;
      result_v_q <= '0;
    end else begin
      wb_ctrl_q  <= ex_mem_i.ctrl;
      wb_rd_q    <= ex_mem_i.rd;
      load_q     <= data_mem_out_data_i;
      result_s_q <= ex_mem_i.result_s;
      result_v_q <= ex_mem_i.result_v;
    end
  end

  // Write-back select
  assign wr.we        = wb_ctrl_q.reg_we;
  assign wr.addr      = wb_rd_q;
  assign wr.is_vector = wb_ctrl_q.is_vector;
  assign wr.sdata     = wb_ctrl_q.mem_read ? load_q : result_s_q;
  assign wr.vdata     = wb_ctrl_q.mem_read ? cpu_isa_pkg::lane_vec_t'(load_q) : result_v_q;

endmodule

// ==== hw/vector_cpu.sv ====
`timescale 1ns/1ns

module vector_cpu (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  logic [cpu_isa_pkg::data_width_lp-1:0] inst_mem_data_i,
  output logic [cpu_isa_pkg::data_width_lp-1:0] inst_mem_address_o,
  input  logic [cpu_isa_pkg::data_width_lp-1:0] data_mem_out_data_i,
  output logic [cpu_isa_pkg::data_width_lp-1:0] data_mem_address_o,
  output logic [cpu_isa_pkg::data_width_lp-1:0] data_mem_in_data_o,
  output logic                                  data_mem_we_o
);

  logic [cpu_isa_pkg::data_width_lp-1:0] inst_id;
  cpu_isa_pkg::reg_addr_t                rs1_addr;
  cpu_isa_pkg::reg_addr_t                rs2_addr;
  logic [cpu_isa_pkg::data_width_lp-1:0] rs1_s;
  logic [cpu_isa_pkg::data_width_lp-1:0] rs2_s;
  cpu_isa_pkg::lane_vec_t                rs1_v;
  cpu_isa_pkg::lane_vec_t                rs2_v;
  cpu_pipe_pkg::id_ex_t                  id_ex;
  cpu_pipe_pkg::ex_mem_t                 ex_mem;

  rf_write_if wb_if ();

  fetch_stage u_fetch (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .inst_i  (inst_mem_data_i),
    .pc_o    (inst_mem_address_o),
    .inst_o  (inst_id)
  );

  decode_stage u_decode (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .inst_i    (inst_id),
    .rs1_addr_o(rs1_addr),
    .rs2_addr_o(rs2_addr),
    .rs1_s_i   (rs1_s),
    .rs2_s_i   (rs2_s),
    .rs1_v_i   (rs1_v),
    .rs2_v_i   (rs2_v),
    .id_ex_o   (id_ex)
  );

  register_file u_regfile (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .rs1_addr_i(rs1_addr),
    .rs2_addr_i(rs2_addr),
    .rs1_s_o   (rs1_s),
    .rs2_s_o   (rs2_s),
    .rs1_v_o   (rs1_v),
    .rs2_v_o   (rs2_v),
    .wr        (wb_if.rf)
  );

  execute_stage u_execute (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .id_ex_i (id_ex),
    .ex_mem_o(ex_mem)
  );

  memory_stage u_memory (
    .clk_i              (clk_i),
    .arst_n_i           (arst_n_i),
    .ex_mem_i           (ex_mem),
    .data_mem_out_data_i(data_mem_out_data_i),
    .data_mem_address_o (data_mem_address_o),
    .data_mem_in_data_o (data_mem_in_data_o),
    .data_mem_we_o      (data_mem_we_o),
    .wr                 (wb_if.wb)
  );

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Release on a falling edge, after 8 cycles
  initial begin
    arst_n_o = 1'b0;
    repeat (8) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

// ==== tests/tb_vector_cpu.sv ====
`timescale 1ns/1ns

module tb_vector_cpu;

  localparam int imem_depth_lp = 256;
  localparam int dmem_depth_lp = 256;
  localparam int prog_slots_lp = 200;
  localparam int timeout_lp    = 1000;

  logic        clk;
  logic        arst_n;
  logic [31:0] inst_data;
  logic [31:0] inst_addr;
  logic [31:0] dmem_rdata;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic        dmem_we;

  logic [31:0] imem [imem_depth_lp];
  logic [31:0] dmem [dmem_depth_lp];
  logic [31:0] model_mem [dmem_depth_lp];
  logic [31:0] model_s [16];
  logic [31:0] model_v [16];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [31:0] store_targets [$];
  logic [4:0]  pending [$];
  logic [4:0]  recent [3];
  int          prog_len;
  int          errors;
  int          checks;
  int          tests;

  tb_clock_gen u_clock_gen (.clk_o(clk), .arst_n_o(arst_n));

  vector_cpu u_vector_cpu (
    .clk_i              (clk),
    .arst_n_i           (arst_n),
    .inst_mem_data_i    (inst_data),
    .inst_mem_address_o (inst_addr),
    .data_mem_out_data_i(dmem_rdata),
    .data_mem_address_o (dmem_addr),
    .data_mem_in_data_o (dmem_wdata),
    .data_mem_we_o      (dmem_we)
  );

  function automatic logic [31:0] sext(input logic [15:0] imm);
    return {{16{imm[15]}}, imm};
  endfunction

  // Each byte wraps on its own
  function automatic logic [31:0] lane_calc(input int kind, input logic [31:0] a,
                                            input logic [31:0] b);
    logic [31:0] r;
    for (int i = 0; i < 4; i++) begin
      case (kind)
        0:       r[i*8 +: 8] = a[i*8 +: 8] + b[i*8 +: 8];
        1:       r[i*8 +: 8] = a[i*8 +: 8] - b[i*8 +: 8];
        2:       r[i*8 +: 8] = a[i*8 +: 8] & b[i*8 +: 8];
        default: r[i*8 +: 8] = a[i*8 +: 8] | b[i*8 +: 8];
      endcase
    end
    return r;
  endfunction

  function automatic bit reads_recent(input logic [3:0] rs1, input logic [3:0] rs2,
                                      input bit uses_rs2);
    bit hit;
    hit = 1'b0;
    for (int i = 0; i < 3; i++) begin
      if (recent[i][4] && (recent[i][3:0] == rs1 || (uses_rs2 && recent[i][3:0] == rs2))) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int base);
    tests++;
    $display("Test %s: %s, %0d mismatches", name, (errors == base) ? "passed" : "failed",
             errors - base);
  endtask

  task automatic emit(input logic [31:0] word, input logic [4:0] wr);
    imem[prog_len] = word;
    prog_len++;
    recent[2] = recent[1];
    recent[1] = recent[0];
    recent[0] = wr;
  endtask

  // Emit one instruction after enough no-ops, then run it on the model
  task automatic place(input cpu_isa_pkg::opcode_e op, input logic [3:0] rd,
                       input logic [3:0] rs1, input logic [3:0] rs2, input logic [15:0] imm);
    logic [31:0] addr;
    bit          uses_rs2;
    bit          writes;
    uses_rs2 = !(op inside {cpu_isa_pkg::op_addi, cpu_isa_pkg::op_lw, cpu_isa_pkg::op_vlw});
    writes   = !(op inside {cpu_isa_pkg::op_sw, cpu_isa_pkg::op_vsw});
    repeat (3) begin
      if (reads_recent(rs1, rs2, uses_rs2)) emit(32'h0, 5'h0);
    end
    emit({op, rd, rs1, rs2, imm}, {writes, rd});
    addr = model_s[rs1] + sext(imm);
    case (op)
      cpu_isa_pkg::op_add:   model_s[rd] = model_s[rs1] + model_s[rs2];
      cpu_isa_pkg::op_sub:   model_s[rd] = model_s[rs1] - model_s[rs2];
      cpu_isa_pkg::op_and:   model_s[rd] = model_s[rs1] & model_s[rs2];
      cpu_isa_pkg::op_or:    model_s[rd] = model_s[rs1] | model_s[rs2];
      cpu_isa_pkg::op_addi:  model_s[rd] = addr;
      cpu_isa_pkg::op_vadd:  model_v[rd] = lane_calc(0, model_v[rs1], model_v[rs2]);
      cpu_isa_pkg::op_vsub:  model_v[rd] = lane_calc(1, model_v[rs1], model_v[rs2]);
      cpu_isa_pkg::op_vand:  model_v[rd] = lane_calc(2, model_v[rs1], model_v[rs2]);
      cpu_isa_pkg::op_vor:   model_v[rd] = lane_calc(3, model_v[rs1], model_v[rs2]);
      cpu_isa_pkg::op_vadds: model_v[rd] = lane_calc(0, model_v[rs1], {4{model_s[rs2][7:0]}});
      cpu_isa_pkg::op_lw:    model_s[rd] = model_mem[addr[7:0]];
      cpu_isa_pkg::op_vlw:   model_v[rd] = model_mem[addr[7:0]];
      default: begin
        model_mem[addr[7:0]] = (op == cpu_isa_pkg::op_vsw) ? model_v[rs2] : model_s[rs2];
        exp_addr.push_back(addr);
        exp_data.push_back(model_mem[addr[7:0]]);
        store_targets.push_back(addr);
      end
    endcase
    if (writes) begin
      pending.push_back({op inside {cpu_isa_pkg::op_vadd, cpu_isa_pkg::op_vsub,
                                    cpu_isa_pkg::op_vand, cpu_isa_pkg::op_vor,
                                    cpu_isa_pkg::op_vadds, cpu_isa_pkg::op_vlw}, rd});
    end
  endtask

  // Results become visible by storing each written register a few slots later
  task automatic build_program();
    cpu_isa_pkg::opcode_e op;
    logic [4:0]           p;
    logic [3:0]           rd;
    logic [3:0]           rs1;
    logic [3:0]           rs2;
    logic [15:0]          imm;
    logic [31:0]          target;
    prog_len = 0;
    recent   = '{default: '0};
    while (prog_len < prog_slots_lp - 8) begin
      rs1 = 4'($urandom_range(0, 15));
      imm = 16'($urandom);
      if (pending.size() >= 3) begin
        p = pending.pop_front();
        place(p[4] ? cpu_isa_pkg::op_vsw : cpu_isa_pkg::op_sw, 4'h0, rs1, p[3:0], imm);
      end else begin
        op  = cpu_isa_pkg::opcode_e'($urandom_range(1, 14));
        rd  = 4'($urandom_range(0, 15));
        rs2 = 4'($urandom_range(0, 15));
        // Half the loads aim at a word stored earlier
        if (op inside {cpu_isa_pkg::op_lw, cpu_isa_pkg::op_vlw} && store_targets.size() > 0
            && $urandom_range(0, 1) == 1) begin
          target = store_targets[$urandom_range(0, store_targets.size() - 1)];
          imm    = {8'h00, target[7:0] - model_s[rs1][7:0]};
        end
        place(op, rd, rs1, rs2, imm);
      end
    end
    for (int i = prog_len; i < imem_depth_lp; i++) imem[i] = '0;
  endtask

  always @(negedge clk) begin
    inst_data  = (inst_addr < imem_depth_lp) ? imem[inst_addr] : '0;
    dmem_rdata = dmem[dmem_addr[7:0]];
  end

  always @(posedge clk) begin
    if (arst_n && dmem_we) begin
      if (exp_addr.size() == 0) begin
        errors++;
        $display("Unexpected store to address %h at %0t ns", dmem_addr, $time);
      end else begin
        check_val(dmem_addr, exp_addr.pop_front(), "store address");
        check_val(dmem_wdata, exp_data.pop_front(), "store data");
      end
      dmem[dmem_addr[7:0]] = dmem_wdata;
    end
  end

  initial begin
    int cycle;
    int base;
    bit released;
    bit finished;
    inst_data  = '0;
    dmem_rdata = '0;
    errors     = 0;
    checks     = 0;
    tests      = 0;
    void'($urandom(32'hec1f_ff43));
    for (int i = 0; i < dmem_depth_lp; i++) begin
      dmem[i]      = $urandom;
      model_mem[i] = dmem[i];
    end
    model_s = '{default: '0};
    model_v = '{default: '0};
    build_program();

    base     = errors;
    released = 1'b0;
    for (cycle = 0; cycle < 50 && !released; cycle++) begin
      @(posedge clk);
      if (arst_n) begin
        released = 1'b1;
      end else begin
        check_val(inst_addr, 0, "fetch address in reset");
        check_val(dmem_we, 0, "store enable in reset");
      end
    end
    if (!released) begin
      errors++;
      $display("Reset was never released");
    end
    report_test("reset", base);

    base     = errors;
    finished = 1'b0;
    cycle    = 0;
    while (released && !finished && cycle < timeout_lp) begin
      check_val(inst_addr, cycle, "fetch address");
      if (cycle < 3) check_val(dmem_we, 0, "store enable before first store");
      if (inst_addr > prog_len + 4) begin
        finished = 1'b1;
      end else begin
        @(posedge clk);
        cycle++;
      end
    end
    if (!finished) begin
      errors++;
      $display("Timeout: fetch address never passed the end of the program");
    end
    report_test("program", base);

    base = errors;
    check_val(exp_addr.size(), 0, "stores never seen");
    report_test("store count", base);

    $display("Tests %0d, checks %0d, mismatches %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== project.f ====
hw/cpu_isa_pkg.sv
hw/cpu_pipe_pkg.sv
hw/rf_write_if.sv
hw/fetch_stage.sv
hw/register_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/vector_cpu.sv
tests/tb_clock_gen.sv
tests/tb_vector_cpu.sv

// ==== Bender.yml ====
package:
  name: vector_cpu

sources:
  - files:
      - hw/cpu_isa_pkg.sv
      - hw/cpu_pipe_pkg.sv
      - hw/rf_write_if.sv
      - hw/fetch_stage.sv
      - hw/register_file.sv
      - hw/decode_stage.sv
      - hw/execute_stage.sv
      - hw/memory_stage.sv
      - hw/vector_cpu.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_vector_cpu.sv
